/* Makefile */
.PHONY: all lint clean

all: obj_dir/Vtb_decode_top
	@out=$$(./obj_dir/Vtb_decode_top); echo "$$out"; echo "$$out" | grep -qF '** PASS **'

obj_dir/Vtb_decode_top: vlog.f $(wildcard rtl/*.sv verif/*.sv verif/*.svh)
	verilator --binary --timing --assert -f vlog.f --top-module tb_decode_top

lint:
	verilator --lint-only --timing --assert -f vlog.f --top-module tb_decode_top

clean:
	rm -rf obj_dir

/* rtl/decode_stage_reg.sv */
// decode stage handshake register
`timescale 1ns/1ps

module decode_stage_reg (
    input  logic                      clk,
    input  logic                      arst_n,
    // fetch side
    input  logic                      in_req,
    output logic                      in_ack,
    // decoder results
    input  rv_decode_pkg::cmd_t       cmd,
    input  rv_decode_pkg::funct3_t    funct3,
    input  rv_decode_pkg::reg_adr_t   shamt,
    input  rv_decode_pkg::csr_adr_t   csr_adr,
    input  rv_decode_pkg::reg_adr_t   csr_uimm,
    input  rv_decode_pkg::fence_set_t fence_pred,
    input  rv_decode_pkg::fence_set_t fence_succ,
    input  rv_decode_pkg::reg_adr_t   rd,
    input  rv_decode_pkg::reg_adr_t   rs1,
    input  rv_decode_pkg::reg_adr_t   rs2,
    input  logic                      illegal,
    input  rv_decode_pkg::xlen_t      imm,
    // execute side
    output logic                      out_req,
    input  logic                      out_ack,
    output rv_decode_pkg::decoded_t   out_dec
);
    import rv_decode_pkg::*;

    dec_state_t state;
    decoded_t   dec_next;
    logic       wb_class;

    // classes that write rd
    assign wb_class = cmd.lui | cmd.auipc | cmd.ld | cmd.alui | cmd.alui_shamt
                    | cmd.alu | cmd.jal | cmd.jalr | cmd.csr;

    // merge both decode paths
    always_comb
    begin
        dec_next.cmd        = cmd;
        dec_next.funct3     = funct3;
        dec_next.shamt      = shamt;
        dec_next.csr_adr    = csr_adr;
        dec_next.csr_uimm   = csr_uimm;
        dec_next.fence_pred = fence_pred;
        dec_next.fence_succ = fence_succ;
        dec_next.rd         = rd;
        dec_next.rs1        = rs1;
        dec_next.rs2        = rs2;
        dec_next.imm        = imm;
        // x0 is never written
        dec_next.wb_en      = ~illegal & (rd != 5'd0) & wb_class;
        dec_next.illegal    = illegal;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            state   <= S_IDLE;
            in_ack  <= 1'b0;
            out_dec <= '0;
        end
        else
        begin
            case (state)
                // capture on request, ack follows a cycle later
                S_IDLE:
                    if (in_req)
                    begin
                        out_dec <= dec_next;
                        state   <= S_IN_ACK;
                    end
                S_IN_ACK:
                    if (!in_ack)
                        in_ack <= 1'b1;
                    else if (!in_req)
                    begin
                        // fetch side closed, offer to execute
                        in_ack <= 1'b0;
                        state  <= S_OUT_REQ;
                    end
                S_OUT_REQ:
                    if (out_ack)
                        state <= S_OUT_DONE;
                // wait for ack to drop before taking more
                S_OUT_DONE:
                    if (!out_ack)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
    end

    assign out_req = (state == S_OUT_REQ);

    // request held until execute answers
    a_req_hold: assert property (@(posedge clk) disable iff (!arst_n)
        out_req && !out_ack |=> out_req)
        else $error("decode_stage_reg: out_req dropped before out_ack");

    // payload frozen during the offer
    a_dec_stable: assert property (@(posedge clk) disable iff (!arst_n)
        out_req |=> $stable(out_dec))
        else $error("decode_stage_reg: out_dec changed while out_req high");

endmodule

/* rtl/decode_top.sv */
// rv32i decode stage top
`timescale 1ns/1ps

module decode_top #(
    parameter bit HAS_SUPERVISOR = 1'b1
) (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_req,
    input  rv_decode_pkg::inst_t    inst,
    output logic                    in_ack,
    output logic                    out_req,
    output rv_decode_pkg::decoded_t out_dec,
    input  logic                    out_ack
);
    import rv_decode_pkg::*;

    // decoder to stage register
    cmd_t       cmd;
    funct3_t    funct3;
    reg_adr_t   shamt;
    csr_adr_t   csr_adr;
    reg_adr_t   csr_uimm;
    fence_set_t fence_pred;
    fence_set_t fence_succ;
    reg_adr_t   rd;
    reg_adr_t   rs1;
    reg_adr_t   rs2;
    logic       illegal;
    // immediate path
    xlen_t      imm;

    inst_decoder #(
        .HAS_SUPERVISOR (HAS_SUPERVISOR)
    ) i_inst_decoder (
        .inst       (inst),
        .cmd        (cmd),
        .funct3     (funct3),
        .shamt      (shamt),
        .csr_adr    (csr_adr),
        .csr_uimm   (csr_uimm),
        .fence_pred (fence_pred),
        .fence_succ (fence_succ),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .illegal    (illegal)
    );

    imm_gen i_imm_gen (
        .inst (inst),
        .imm  (imm)
    );

    decode_stage_reg i_decode_stage_reg (
        .clk        (clk),
        .arst_n     (arst_n),
        .in_req     (in_req),
        .in_ack     (in_ack),
        .cmd        (cmd),
        .funct3     (funct3),
        .shamt      (shamt),
        .csr_adr    (csr_adr),
        .csr_uimm   (csr_uimm),
        .fence_pred (fence_pred),
        .fence_succ (fence_succ),
        .rd         (rd),
        .rs1        (rs1),
        .rs2        (rs2),
        .illegal    (illegal),
        .imm        (imm),
        .out_req    (out_req),
        .out_ack    (out_ack),
        .out_dec    (out_dec)
    );

endmodule

/* rtl/imm_gen.sv */
// rv32i immediate generator
`timescale 1ns/1ps

module imm_gen (
    input  rv_decode_pkg::inst_t inst,
    output rv_decode_pkg::xlen_t imm
);
    import rv_decode_pkg::*;

    opcode_t op;
    // format one-hot, i s b u j
    logic [4:0] fmt;
    logic       sgn;
    xlen_t      imm_i;
    xlen_t      imm_s;
    xlen_t      imm_b;
    xlen_t      imm_u;
    xlen_t      imm_j;

    assign op  = inst[6:2];
    // every format takes its sign from bit 31
    assign sgn = inst[31];

    // format from the opcode alone
    always_comb
    begin
        fmt = 5'b00000;
        case (op)
            OP_LOAD,
            OP_IMM,
            OP_JALR,
            OP_SYSTEM: fmt = 5'b00001;
            OP_STORE:  fmt = 5'b00010;
            OP_BRANCH: fmt = 5'b00100;
            OP_LUI,
            OP_AUIPC:  fmt = 5'b01000;
            OP_JAL:    fmt = 5'b10000;
            default:   fmt = 5'b00000;
        endcase
    end

    // assembled and sign extended
    assign imm_i = {{20{sgn}}, inst[31:20]};
    assign imm_s = {{20{sgn}}, inst[31:25], inst[11:7]};
    // bit 0 always zero for branch and jal
    assign imm_b = {{19{sgn}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
    assign imm_u = {inst[31:12], 12'd0};
    assign imm_j = {{11{sgn}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};

    // and-or mux, zero when no format
    assign imm = ({32{fmt[0]}} & imm_i)
               | ({32{fmt[1]}} & imm_s)
               | ({32{fmt[2]}} & imm_b)
               | ({32{fmt[3]}} & imm_u)
               | ({32{fmt[4]}} & imm_j);

endmodule

/* rtl/inst_decoder.sv */
// rv32i instruction decoder
`timescale 1ns/1ps

module inst_decoder #(
    parameter bit HAS_SUPERVISOR = 1'b1
) (
    input  rv_decode_pkg::inst_t      inst,
    output rv_decode_pkg::cmd_t       cmd,
    output rv_decode_pkg::funct3_t    funct3,
    output rv_decode_pkg::reg_adr_t   shamt,
    output rv_decode_pkg::csr_adr_t   csr_adr,
    output rv_decode_pkg::reg_adr_t   csr_uimm,
    output rv_decode_pkg::fence_set_t fence_pred,
    output rv_decode_pkg::fence_set_t fence_succ,
    output rv_decode_pkg::reg_adr_t   rd,
    output rv_decode_pkg::reg_adr_t   rs1,
    output rv_decode_pkg::reg_adr_t   rs2,
    output logic                      illegal
);
    import rv_decode_pkg::*;

    opcode_t    op;
    logic [4:0] f7_hi;
    logic [7:0] f3_dc;
    logic       notc;
    logic       is_lui;
    logic       is_auipc;
    logic       is_jal;
    logic       is_jalr;
    logic       is_branch;
    logic       is_load;
    logic       is_store;
    logic       is_imm;
    logic       is_reg;
    logic       is_fence;
    logic       is_system;
    logic       f7_00000;
    logic       f7_01000;
    logic       f7_00010;
    logic       f7_00110;
    logic       r2_00000;
    logic       r2_00001;
    logic       r2_00010;
    logic       r2_00101;
    logic       op5_01;
    logic       z_26_25;
    logic       z_31_28;
    logic       z_19_15;
    logic       z_11_7;
    logic       z_pred;
    logic       z_succ;
    logic       ec;
    logic [19:0] cls;

    // field slices
    assign op         = inst[6:2];
    assign f7_hi      = inst[31:27];
    assign rd         = inst[11:7];
    assign rs1        = inst[19:15];
    assign rs2        = inst[24:20];
    assign funct3     = inst[14:12];
    assign shamt      = inst[24:20];
    assign csr_adr    = inst[31:20];
    // uimm sits in the rs1 slot
    assign csr_uimm   = inst[19:15];
    assign fence_pred = inst[27:24];
    assign fence_succ = inst[23:20];

    // 32-bit encodings only, compressed is illegal
    assign notc = (inst[1:0] == 2'b11);

    // opcode one-hot
    assign is_lui    = (op == OP_LUI);
    assign is_auipc  = (op == OP_AUIPC);
    assign is_jal    = (op == OP_JAL);
    assign is_jalr   = (op == OP_JALR);
    assign is_branch = (op == OP_BRANCH);
    assign is_load   = (op == OP_LOAD);
    assign is_store  = (op == OP_STORE);
    assign is_imm    = (op == OP_IMM);
    assign is_reg    = (op == OP_REG);
    assign is_fence  = (op == OP_FENCE);
    assign is_system = (op == OP_SYSTEM);

    // funct3 one-hot
    assign f3_dc = 8'd1 << funct3;

    // funct7 high bits
    assign f7_00000 = (f7_hi == 5'b00000);
    assign f7_01000 = (f7_hi == 5'b01000);
    assign f7_00010 = (f7_hi == 5'b00010);
    assign f7_00110 = (f7_hi == 5'b00110);

    // rs2 slot used as a sub-opcode by system ops
    assign r2_00000 = (rs2 == 5'b00000);
    assign r2_00001 = (rs2 == 5'b00001);
    assign r2_00010 = (rs2 == 5'b00010);
    assign r2_00101 = (rs2 == 5'b00101);
    assign op5_01   = (inst[26:25] == 2'b01);

    // zero-field checks
    assign z_26_25 = (inst[26:25] == 2'b00);
    assign z_31_28 = (inst[31:28] == 4'd0);
    assign z_19_15 = (rs1 == 5'd0);
    assign z_11_7  = (rd == 5'd0);
    assign z_pred  = (fence_pred == 4'd0);
    assign z_succ  = (fence_succ == 4'd0);

    // shared part of ecall, ebreak and the returns
    assign ec = is_system & f3_dc[0] & notc & z_26_25 & z_19_15 & z_11_7;

    always_comb
    begin
        cmd = '0;
        cmd.lui   = is_lui & notc;
        cmd.auipc = is_auipc & notc;
        // lb lh lw lbu lhu
        cmd.ld    = is_load & notc & ~(f3_dc[3] | f3_dc[6] | f3_dc[7]);
        cmd.alui  = is_imm & notc & ~(f3_dc[1] | f3_dc[5]);
        // slli, srli, srai
        cmd.alui_shamt = is_imm & notc & z_26_25
                       & ((f3_dc[1] & f7_00000) | (f3_dc[5] & (f7_00000 | f7_01000)));
        // funct7 0100000 only for sub and sra
        cmd.alu     = is_reg & notc & z_26_25
                    & (f7_00000 | (f7_01000 & (f3_dc[0] | f3_dc[5])));
        cmd.alu_sub = cmd.alu & f7_01000;
        // sb sh sw
        cmd.st   = is_store & notc & (f3_dc[0] | f3_dc[1] | f3_dc[2]);
        cmd.jal  = is_jal & notc;
        cmd.jalr = is_jalr & notc & f3_dc[0];
        cmd.br   = is_branch & notc & ~(f3_dc[2] | f3_dc[3]);
        cmd.fence  = is_fence & f3_dc[0] & notc & z_31_28 & z_19_15 & z_11_7;
        cmd.fencei = is_fence & f3_dc[1] & notc & z_31_28 & z_pred & z_succ
                   & z_19_15 & z_11_7;
        // supervisor ops vanish without S mode
        cmd.sfence = is_system & f3_dc[0] & notc & f7_00010 & op5_01 & z_11_7
                   & HAS_SUPERVISOR;
        // funct3 100 is reserved
        cmd.csr    = is_system & notc & ~(f3_dc[0] | f3_dc[4]);
        cmd.ecall  = ec & f7_00000 & r2_00000;
        cmd.ebreak = ec & f7_00000 & r2_00001;
        cmd.uret   = ec & f7_00000 & r2_00010;
        cmd.sret   = ec & f7_00010 & r2_00010 & HAS_SUPERVISOR;
        cmd.mret   = ec & f7_00110 & r2_00010;
        cmd.wfi    = ec & f7_00010 & r2_00101;
    end

    // class flags, alu_sub left out
    assign cls = {cmd.lui, cmd.auipc, cmd.ld, cmd.alui, cmd.alui_shamt,
                  cmd.alu, cmd.st, cmd.jal, cmd.jalr, cmd.br,
                  cmd.fence, cmd.fencei, cmd.sfence, cmd.csr, cmd.ecall,
                  cmd.ebreak, cmd.uret, cmd.sret, cmd.mret, cmd.wfi};

    // nothing matched
    assign illegal = ~|cls;

    // one class per instruction, sub only on alu
    a_one_class: assert property (@(cmd) $onehot0(cls) && (cmd.alu || !cmd.alu_sub))
        else $error("inst_decoder: more than one command class set");

endmodule

/* rtl/rv_decode_pkg.sv */
// rv32i decode types and opcodes
package rv_decode_pkg;

    // plain vector types
    typedef logic [31:0] inst_t;
    typedef logic [31:0] xlen_t;
    typedef logic [4:0]  reg_adr_t;
    typedef logic [2:0]  funct3_t;
    typedef logic [11:0] csr_adr_t;
    typedef logic [3:0]  fence_set_t;
    typedef logic [4:0]  opcode_t;

    // major opcodes, inst[6:2]
    localparam opcode_t OP_LUI    = 5'b01101;
    localparam opcode_t OP_AUIPC  = 5'b00101;
    localparam opcode_t OP_JAL    = 5'b11011;
    localparam opcode_t OP_JALR   = 5'b11001;
    localparam opcode_t OP_BRANCH = 5'b11000;
    localparam opcode_t OP_LOAD   = 5'b00000;
    localparam opcode_t OP_STORE  = 5'b01000;
    localparam opcode_t OP_IMM    = 5'b00100;
    localparam opcode_t OP_REG    = 5'b01100;
    localparam opcode_t OP_FENCE  = 5'b00011;
    localparam opcode_t OP_SYSTEM = 5'b11100;

    // command flags, one class at a time
    // alu_sub rides along with alu only
    typedef struct packed {
        logic lui;
        logic auipc;
        logic ld;
        logic alui;
        logic alui_shamt;
        logic alu;
        logic alu_sub;
        logic st;
        logic jal;
        logic jalr;
        logic br;
        logic fence;
        logic fencei;
        logic sfence;
        logic csr;
        logic ecall;
        logic ebreak;
        logic uret;
        logic sret;
        logic mret;
        logic wfi;
    } cmd_t;

    // word handed to execute
    typedef struct packed {
        cmd_t       cmd;
        // alu code or csr op
        funct3_t    funct3;
        reg_adr_t   shamt;
        csr_adr_t   csr_adr;
        reg_adr_t   csr_uimm;
        fence_set_t fence_pred;
        fence_set_t fence_succ;
        reg_adr_t   rd;
        reg_adr_t   rs1;
        reg_adr_t   rs2;
        xlen_t      imm;
        logic       wb_en;
        logic       illegal;
    } decoded_t;

    // stage handshake states
    typedef enum logic [1:0] {
        S_IDLE,
        S_IN_ACK,
        S_OUT_REQ,
        S_OUT_DONE
    } dec_state_t;

endpackage

/* verif/decode_ref.svh */
// decode reference model and stimulus
`ifndef DECODE_REF_SVH
`define DECODE_REF_SVH

// legal major opcodes for the random generator
localparam opcode_t OP_TABLE [11] = '{
    OP_LUI, OP_AUIPC, OP_JAL, OP_JALR, OP_BRANCH, OP_LOAD,
    OP_STORE, OP_IMM, OP_REG, OP_FENCE, OP_SYSTEM
};

// galois lfsr state, taps 16 14 13 11
logic [15:0] lfsr = 16'd8;

// one lfsr step per bit taken
function automatic logic rand_bit();
    logic lsb;
    lsb  = lfsr[0];
    lfsr = {1'b0, lfsr[15:1]} ^ (lsb ? 16'hB400 : 16'h0000);
    return lsb;
endfunction

function automatic logic [31:0] rand_bits(int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
        v = {v[30:0], rand_bit()};
    return v;
endfunction

// every eighth word fully random, the rest on a legal opcode
function automatic inst_t gen_inst(int k);
    inst_t w;
    int    idx;
    if (k % 8 == 7)
        w = rand_bits(32);
    else
    begin
        idx     = int'(rand_bits(4) % 32'd11);
        w[31:7] = 25'(rand_bits(25));
        // lean funct7 toward the codes that decode
        case (rand_bits(2))
            32'd0:   w[31:25] = 7'h00;
            32'd1:   w[31:25] = 7'h20;
            default: ;
        endcase
        w[6:2] = OP_TABLE[idx];
        w[1:0] = 2'b11;
    end
    return w;
endfunction

// expected decoded word, straight from the rv32i encoding tables
function automatic decoded_t decode_ref(inst_t w, bit has_sup);
    decoded_t           d;
    logic [6:0]         f7;
    logic [2:0]         f3;
    logic signed [11:0] imm_i;
    logic signed [11:0] imm_s;
    logic signed [12:0] imm_b;
    logic signed [20:0] imm_j;
    d     = '0;
    f7    = w[31:25];
    f3    = w[14:12];
    imm_i = w[31:20];
    imm_s = {w[31:25], w[11:7]};
    imm_b = {w[31], w[7], w[30:25], w[11:8], 1'b0};
    imm_j = {w[31], w[19:12], w[20], w[30:21], 1'b0};
    // raw fields pass through for any word
    d.funct3     = f3;
    d.shamt      = w[24:20];
    d.csr_adr    = w[31:20];
    d.csr_uimm   = w[19:15];
    d.fence_pred = w[27:24];
    d.fence_succ = w[23:20];
    d.rd         = w[11:7];
    d.rs1        = w[19:15];
    d.rs2        = w[24:20];
    // compressed words decode to nothing
    if (w[1:0] == 2'b11)
    begin
        case (w[6:2])
            OP_LUI:    d.cmd.lui   = 1'b1;
            OP_AUIPC:  d.cmd.auipc = 1'b1;
            OP_JAL:    d.cmd.jal   = 1'b1;
            OP_JALR:   d.cmd.jalr  = (f3 == 3'd0);
            OP_BRANCH: d.cmd.br    = (f3 != 3'd2) && (f3 != 3'd3);
            OP_LOAD:   d.cmd.ld    = (f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5});
            OP_STORE:  d.cmd.st    = (f3 <= 3'd2);
            OP_IMM:
            begin
                // shifts want a clean funct7, srai allows 0100000
                if (f3 == 3'd1)
                    d.cmd.alui_shamt = (f7 == 7'h00);
                else if (f3 == 3'd5)
                    d.cmd.alui_shamt = (f7 == 7'h00) || (f7 == 7'h20);
                else
                    d.cmd.alui = 1'b1;
            end
            OP_REG:
            begin
                d.cmd.alu     = (f7 == 7'h00)
                              || ((f7 == 7'h20) && ((f3 == 3'd0) || (f3 == 3'd5)));
                d.cmd.alu_sub = d.cmd.alu && (f7 == 7'h20);
            end
            OP_FENCE:
            begin
                if ((d.rs1 == 5'd0) && (d.rd == 5'd0))
                begin
                    d.cmd.fence  = (f3 == 3'd0) && (w[31:28] == 4'd0);
                    d.cmd.fencei = (f3 == 3'd1) && (w[31:20] == 12'd0);
                end
            end
            OP_SYSTEM:
            begin
                // funct3 100 reserved
                if (f3 != 3'd0)
                    d.cmd.csr = (f3 != 3'd4);
                else if (d.rd == 5'd0)
                begin
                    d.cmd.sfence = (f7 == 7'h09) && has_sup;
                    if (d.rs1 == 5'd0)
                    begin
                        case (w[31:20])
                            12'h000: d.cmd.ecall  = 1'b1;
                            12'h001: d.cmd.ebreak = 1'b1;
                            12'h002: d.cmd.uret   = 1'b1;
                            12'h102: d.cmd.sret   = has_sup;
                            12'h302: d.cmd.mret   = 1'b1;
                            12'h105: d.cmd.wfi    = 1'b1;
                            default: ;
                        endcase
                    end
                end
            end
            default: ;
        endcase
    end
    // immediate by opcode alone, legality ignored
    case (w[6:2])
        OP_LOAD, OP_IMM, OP_JALR, OP_SYSTEM: d.imm = 32'(imm_i);
        OP_STORE:                            d.imm = 32'(imm_s);
        OP_BRANCH:                           d.imm = 32'(imm_b);
        OP_LUI, OP_AUIPC:                    d.imm = {w[31:12], 12'h000};
        OP_JAL:                              d.imm = 32'(imm_j);
        default:                             d.imm = '0;
    endcase
    d.illegal = (d.cmd == '0);
    // x0 is never a write target
    d.wb_en = !d.illegal && (d.rd != 5'd0)
            && (d.cmd.lui || d.cmd.auipc || d.cmd.ld || d.cmd.alui || d.cmd.alui_shamt
                || d.cmd.alu || d.cmd.jal || d.cmd.jalr || d.cmd.csr);
    return d;
endfunction

`endif

/* verif/tb_decode_top.sv */
// decode stage testbench
`timescale 1ns/1ps

module tb_decode_top;
    import rv_decode_pkg::*;

    localparam bit HAS_SUP  = 1'b1;
    localparam int N_RANDOM = 300;
    localparam int TIMEOUT  = 100;
    localparam int N_DIR    = 36;

    logic     clk;
    logic     arst_n;
    logic     in_req;
    inst_t    inst;
    logic     in_ack;
    logic     out_req;
    decoded_t out_dec;
    logic     out_ack;

    // words sent by fetch and not yet seen at execute
    inst_t    sent_q[$];
    int       n_sent;
    int       n_checked;

    localparam inst_t DIRECTED [N_DIR] = '{
        // nop lui auipc lw and negative addi
        32'h00000013, 32'hABCDE2B7, 32'h12345317, 32'hFFC12383, 32'hFFF08093,
        // slli srai add sub and negative sw
        32'h00721193, 32'h41F25193, 32'h00C58533, 32'h40C58533, 32'hFE512C23,
        // backward jal, jalr, backward beq, fence and fence.i
        32'hFF1FF0EF, 32'h00008067, 32'hFE208CE3, 32'h0FF0000F, 32'h0000100F,
        // csrrw, csrrwi to x0, ecall ebreak uret
        32'h300312F3, 32'h3408D073, 32'h00000073, 32'h00100073, 32'h00200073,
        // sret mret wfi sfence.vma and addi to x0
        32'h10200073, 32'h30200073, 32'h10500073, 32'h12208073, 32'h00528013,
        // positive immediates on addi sw and bne
        32'h7FF00093, 32'h06112223, 32'h00209863,
        // compressed words and unknown opcodes
        32'h00004501, 32'hFFF00011, 32'h0000007F, 32'h0000002F,
        // nonzero reserved fields and bad funct7
        32'h00008073, 32'h0000108F, 32'h02C58533, 32'h40721193
    };

    `include "decode_ref.svh"

    initial
    begin
        clk = 1'b0;
        forever
            #10 clk = ~clk;
    end

    decode_top #(
        .HAS_SUPERVISOR (HAS_SUP)
    ) i_dut (
        .clk     (clk),
        .arst_n  (arst_n),
        .in_req  (in_req),
        .inst    (inst),
        .in_ack  (in_ack),
        .out_req (out_req),
        .out_dec (out_dec),
        .out_ack (out_ack)
    );

    task automatic abort_run(string msg);
        $display("%s", msg);
        $display("** FAIL **");
        $fatal(1);
    endtask

    // one clock, bounded
    task automatic next_cycle(inout int t, input string what);
        @(posedge clk);
        t++;
        if (t > TIMEOUT)
            abort_run({"timeout: ", what});
    endtask

    task automatic check_field(string name, logic [31:0] got, logic [31:0] exp);
        assert (got === exp)
        else
            abort_run($sformatf("Error: %0t %s got %0h expected %0h",
                                $time, name, got, exp));
    endtask

    task automatic check_stable(decoded_t held);
        assert (out_dec === held)
        else
            abort_run($sformatf(
                "Error: %0t out_dec changed while out_req high, got %h expected %h",
                $time, out_dec, held));
    endtask

    // offered word against the reference decode
    task automatic check_word(inst_t w);
        decoded_t r;
        r = decode_ref(w, HAS_SUP);
        check_field("out_dec.cmd", 32'(out_dec.cmd), 32'(r.cmd));
        check_field("out_dec.funct3", 32'(out_dec.funct3), 32'(r.funct3));
        check_field("out_dec.shamt", 32'(out_dec.shamt), 32'(r.shamt));
        check_field("out_dec.csr_adr", 32'(out_dec.csr_adr), 32'(r.csr_adr));
        check_field("out_dec.csr_uimm", 32'(out_dec.csr_uimm), 32'(r.csr_uimm));
        check_field("out_dec.fence_pred", 32'(out_dec.fence_pred), 32'(r.fence_pred));
        check_field("out_dec.fence_succ", 32'(out_dec.fence_succ), 32'(r.fence_succ));
        check_field("out_dec.rd", 32'(out_dec.rd), 32'(r.rd));
        check_field("out_dec.rs1", 32'(out_dec.rs1), 32'(r.rs1));
        check_field("out_dec.rs2", 32'(out_dec.rs2), 32'(r.rs2));
        check_field("out_dec.imm", out_dec.imm, r.imm);
        check_field("out_dec.wb_en", 32'(out_dec.wb_en), 32'(r.wb_en));
        check_field("out_dec.illegal", 32'(out_dec.illegal), 32'(r.illegal));
    endtask

    // fetch side of the four-phase handshake, entered on a rising edge
    task automatic send_inst(inst_t w);
        int t;
        inst   <= w;
        in_req <= 1'b1;
        sent_q.push_back(w);
        n_sent++;
        t = 0;
        do
            next_cycle(t, "fetch handshake stalled, in_ack never rose");
        while (!in_ack);
        in_req <= 1'b0;
        t = 0;
        do
            next_cycle(t, "fetch handshake stalled, in_ack never fell");
        while (in_ack);
    endtask

    // execute side, compares each offer and acks after a random delay
    task automatic run_compare(int n);
        int       t;
        int       delay;
        decoded_t held;
        for (int i = 0; i < n; i++)
        begin
            t = 0;
            do
                next_cycle(t, "execute handshake stalled, out_req never rose");
            while (!out_req);
            assert (sent_q.size() > 0)
            else
                abort_run("out_req raised with no instruction outstanding");
            check_word(sent_q.pop_front());
            held  = out_dec;
            delay = int'(rand_bits(3));
            // back-pressure of 0 to 7 cycles
            repeat (delay)
            begin
                @(posedge clk);
                assert (out_req)
                else
                    abort_run("out_req dropped before out_ack was raised");
                check_stable(held);
            end
            out_ack <= 1'b1;
            t = 0;
            do
            begin
                next_cycle(t, "execute handshake stalled, out_req never fell");
                if (out_req)
                    check_stable(held);
            end
            while (out_req);
            out_ack <= 1'b0;
            n_checked++;
        end
    endtask

    task automatic wait_drained();
        int t;
        t = 0;
        while (n_checked != n_sent)
            next_cycle(t, "decoded words not all delivered to execute");
    endtask

    initial
    begin
        n_sent    = 0;
        n_checked = 0;
        arst_n  <= 1'b0;
        in_req  <= 1'b0;
        inst    <= '0;
        out_ack <= 1'b0;
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        // quiet outputs once out of reset
        @(posedge clk);
        check_field("in_ack", 32'(in_ack), 32'd0);
        check_field("out_req", 32'(out_req), 32'd0);
        assert (out_dec == '0)
        else
            abort_run($sformatf("Error: %0t out_dec got %h expected 0", $time, out_dec));
        fork
            run_compare(N_DIR + N_RANDOM);
        join_none
        for (int i = 0; i < N_DIR; i++)
        begin
            @(posedge clk);
            send_inst(DIRECTED[i]);
        end
        for (int k = 0; k < N_RANDOM; k++)
        begin
            // next word drawn one edge after the last offer
            @(posedge clk);
            send_inst(gen_inst(k));
        end
        wait_drained();
        $display("** PASS **");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+verif
rtl/rv_decode_pkg.sv
rtl/inst_decoder.sv
rtl/imm_gen.sv
rtl/decode_stage_reg.sv
rtl/decode_top.sv
verif/tb_decode_top.sv
